// File: design/lm80c_pkg.sv
/* widths, boot signature bytes, erase fill byte, arbiter source order
   and the ram request struct shared by the memory supervisor */
package lm80c_pkg;

	// only the low 16 address bits reach the system ram
	localparam int RAM_ADDR_W = 16;
	localparam int DATA_W     = 8;

	// cpu runs at sys_clock / 8
	localparam int ENA_DIV   = 8;
	localparam int ENA_CNT_W = 3;

	localparam int CHECK_LEN = 4;   // bytes compared after boot

	typedef logic [RAM_ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0]     byte_t;

	// first boot bytes of a good rom, index = address
	localparam logic [CHECK_LEN-1:0][DATA_W-1:0] ROM_SIGNATURE = {
		8'h02,   // addr 3
		8'h5a,   // addr 2
		8'hc3,   // addr 1
		8'hf3    // addr 0, di
	};

	localparam byte_t ERASE_FILL = 8'h00;

	// one ram access as seen by every request source
	typedef struct packed {
		addr_t addr;
		byte_t data;
		logic  wr;   // write strobe
		logic  rd;   // read enable
	} mem_req_t;

	// arbiter sources, highest priority first
	typedef enum logic [1:0] {
		SRC_DOWNLOAD,
		SRC_ERASE,
		SRC_CHECK,
		SRC_CPU
	} src_t;

endpackage

// File: design/boot_control.sv
/* cpu clock enable divider plus the core reset and cpu wait levels */
module boot_control (
	input  logic sys_clock,
	input  logic RESET,
	input  logic reset_key,     // board reset key level
	input  logic rom_loaded,
	input  logic downloading,
	input  logic erase_busy,
	input  logic check_busy,
	input  logic check_done,
	output logic cpu_ena,       // one clock in ENA_DIV
	output logic core_reset,
	output logic cpu_wait
);

	logic [lm80c_pkg::ENA_CNT_W-1:0] ena_cnt;

	// divider, pulse registered so it is low during reset
	always_ff @(posedge sys_clock) begin
		if (RESET) begin
			ena_cnt <= '0;
			cpu_ena <= 1'b0;
		end else begin
			cpu_ena <= (ena_cnt == '0);   // first pulse right after reset
			if (int'(ena_cnt) == lm80c_pkg::ENA_DIV - 1) begin
				ena_cnt <= '0;
			end else begin
				ena_cnt <= ena_cnt + 1'b1;
			end
		end
	end

	// core held in reset while booting, on the key, or while ram is wiped
	assign core_reset = ~rom_loaded | reset_key | erase_busy;

	// cpu stalled until the rom is in and the boot check has finished
	assign cpu_wait = ~rom_loaded | downloading | check_busy | ~check_done;

	// strobe is single cycle and strictly periodic
	a_ena_period : assert property (
		@(posedge sys_clock) disable iff (RESET)
		cpu_ena |=> !cpu_ena [*lm80c_pkg::ENA_DIV-1] ##1 cpu_ena
	) else $error("cpu_ena broke its period");

endmodule

// File: design/ram_eraser.sv
/* ram eraser, walks all 64 KiB writing the fill byte once per cpu enable */
module ram_eraser (
	input  logic                sys_clock,
	input  logic                RESET,
	input  logic                cpu_ena,
	input  logic                erase_trigger,   // pulse, ignored while busy
	output logic                erase_busy,
	output lm80c_pkg::mem_req_t erase_req
);

	lm80c_pkg::addr_t erase_addr;   // next address to clear

	always_ff @(posedge sys_clock) begin
		if (RESET) begin
			erase_busy <= 1'b0;
			erase_addr <= '0;
		end else if (!erase_busy) begin
			// idle, wait for a trigger
			if (erase_trigger) begin
				erase_busy <= 1'b1;
				erase_addr <= '0;
			end
		end else if (cpu_ena) begin
			erase_addr <= erase_addr + 1'b1;   // wraps back to 0 at the end
			if (erase_addr == '1) begin
				erase_busy <= 1'b0;   // top address written
			end
		end
	end

	// one write per enable while busy
	always_comb begin
		erase_req.addr = erase_addr;
		erase_req.data = lm80c_pkg::ERASE_FILL;
		erase_req.wr   = erase_busy & cpu_ena;
		erase_req.rd   = 1'b1;
	end

	// busy only drops after the top address got its write
	a_fall_top : assert property (
		@(posedge sys_clock) disable iff (RESET)
		$fell(erase_busy) |-> $past(erase_req.wr && erase_req.addr == '1)
	) else $error("erase run ended early");

endmodule

// File: design/rom_checker.sv
/* boot rom checker, reads the first four bytes after a core reset,
   matches them with the signature and drives the active low led */
module rom_checker (
	input  logic                sys_clock,
	input  logic                RESET,
	input  logic                core_reset,   // rerun after every core reset
	input  logic                cpu_ena,
	input  logic                rom_loaded,
	input  lm80c_pkg::byte_t    rdata,
	output logic                check_busy,
	output logic                check_done,
	output lm80c_pkg::mem_req_t check_req,
	output logic                led           // low = signature ok
);

	localparam int STEP_W = $clog2(lm80c_pkg::CHECK_LEN + 1);
	localparam int IDX_W  = $clog2(lm80c_pkg::CHECK_LEN);

	logic [STEP_W-1:0] step;        // enables taken in this run
	logic [STEP_W-1:0] match_cnt;   // bytes that matched so far
	lm80c_pkg::addr_t  check_addr;  // address on the ram port
	logic              hit;
	logic              chk_reset;

	assign chk_reset = RESET | core_reset;

	// rdata belongs to check_addr, it had a whole enable period to settle
	assign hit = (step != '0) &&
		(rdata == lm80c_pkg::ROM_SIGNATURE[check_addr[IDX_W-1:0]]);

	always_ff @(posedge sys_clock) begin
		if (chk_reset) begin
			check_busy <= 1'b0;
			check_done <= 1'b0;
			step       <= '0;
			match_cnt  <= '0;
			check_addr <= '0;
			led        <= 1'b1;   // off until proven good
		end else begin
			if (rom_loaded && !check_done && !check_busy) begin
				check_busy <= 1'b1;
			end
			if (check_busy && cpu_ena) begin
				step       <= step + 1'b1;
				check_addr <= lm80c_pkg::addr_t'(step);   // present next byte
				if (hit) begin
					match_cnt <= match_cnt + 1'b1;
				end
				// fifth enable, last compare
				if (int'(step) == lm80c_pkg::CHECK_LEN) begin
					check_busy <= 1'b0;
					check_done <= 1'b1;
					led <= (int'(match_cnt) + int'(hit)) != lm80c_pkg::CHECK_LEN;
				end
			end
		end
	end

	// read only port
	always_comb begin
		check_req.addr = check_addr;
		check_req.data = '0;
		check_req.wr   = 1'b0;
		check_req.rd   = 1'b1;
	end

	a_busy_done : assert property (
		@(posedge sys_clock) disable iff (chk_reset)
		!(check_busy && check_done)
	) else $error("check busy and done at once");

endmodule

// File: design/ram_arbiter.sv
/* fixed priority ram arbiter: download, eraser, rom checker, cpu */
module ram_arbiter (
	input  lm80c_pkg::mem_req_t download_req,
	input  lm80c_pkg::mem_req_t erase_req,
	input  lm80c_pkg::mem_req_t check_req,
	input  lm80c_pkg::mem_req_t cpu_req,
	input  logic                downloading,
	input  logic                erase_busy,
	input  logic                check_busy,
	output lm80c_pkg::mem_req_t ram_req
);

	lm80c_pkg::src_t src;   // winning source

	// download only wins on its own write strobes
	always_comb begin
		if (downloading && download_req.wr) begin
			src = lm80c_pkg::SRC_DOWNLOAD;
		end else if (erase_busy) begin
			src = lm80c_pkg::SRC_ERASE;
		end else if (check_busy) begin
			src = lm80c_pkg::SRC_CHECK;
		end else begin
			src = lm80c_pkg::SRC_CPU;
		end
	end

	always_comb begin
		case (src)
			lm80c_pkg::SRC_DOWNLOAD: ram_req = download_req;
			lm80c_pkg::SRC_ERASE:    ram_req = erase_req;
			lm80c_pkg::SRC_CHECK:    ram_req = check_req;
			default: begin
				ram_req    = cpu_req;
				ram_req.wr = cpu_req.wr & ~downloading;   // rom image is protected
			end
		endcase
	end

endmodule

// File: design/sys_ram.sv
/* 64 KiB single port system ram, synchronous write, registered read */
module sys_ram (
	input  logic                sys_clock,
	input  lm80c_pkg::mem_req_t req,
	output lm80c_pkg::byte_t    rdata   // data for the address one clock back
);

	// inferred block ram, contents undefined until written
	lm80c_pkg::byte_t mem [2**lm80c_pkg::RAM_ADDR_W];

	always_ff @(posedge sys_clock) begin
		if (req.wr) begin
			mem[req.addr] <= req.data;
		end
		if (req.rd) begin
			// write first, a write shows its own data
			if (req.wr) begin
				rdata <= req.data;
			end else begin
				rdata <= mem[req.addr];
			end
		end
	end

endmodule

// File: design/audio_dac.sv
/* first order delta sigma dac for one 8 bit audio channel */
module audio_dac (
	input  logic       sys_clock,
	input  logic       RESET,
	input  logic [7:0] sample,    // unsigned level
	output logic       dac_out    // density of ones = sample / 256
);

	logic [8:0] acc;   // bit 8 is the carry out

	// carry of each add is the output bit, residue stays in the low byte
	always_ff @(posedge sys_clock) begin
		if (RESET) begin
			acc <= '0;
		end else begin
			acc <= {1'b0, acc[7:0]} + {1'b0, sample};
		end
	end

	assign dac_out = acc[8];

endmodule

// File: design/lm80c_memsys.sv
/* lm80c memory and boot supervisor top, boot control, eraser, rom check,
   ram arbiter, system ram and the two audio dacs */
module lm80c_memsys (
	input  logic                sys_clock,
	input  logic                RESET,          // pll not locked
	input  logic                reset_key,
	input  logic                downloading,
	input  logic                rom_loaded,
	input  logic                download_wr,
	input  lm80c_pkg::addr_t    download_addr,
	input  lm80c_pkg::byte_t    download_data,
	input  logic                erase_trigger,
	input  lm80c_pkg::mem_req_t cpu_req,        // external cpu memory port
	input  lm80c_pkg::byte_t    channel_l,
	input  lm80c_pkg::byte_t    channel_r,
	output logic                cpu_ena,
	output logic                core_reset,
	output logic                cpu_wait,
	output lm80c_pkg::byte_t    cpu_rdata,
	output logic                led,
	output logic                audio_l,
	output logic                audio_r
);

	logic                erase_busy;
	logic                check_busy;
	logic                check_done;
	lm80c_pkg::mem_req_t download_req;
	lm80c_pkg::mem_req_t erase_req;
	lm80c_pkg::mem_req_t check_req;
	lm80c_pkg::mem_req_t ram_req;
	lm80c_pkg::byte_t    ram_rdata;

	// downloader strobes as a request, read kept on like the other sources
	assign download_req = '{addr: download_addr, data: download_data,
		wr: download_wr, rd: 1'b1};

	boot_control i_boot_control (
		.sys_clock  (sys_clock),
		.RESET      (RESET),
		.reset_key  (reset_key),
		.rom_loaded (rom_loaded),
		.downloading(downloading),
		.erase_busy (erase_busy),
		.check_busy (check_busy),
		.check_done (check_done),
		.cpu_ena    (cpu_ena),
		.core_reset (core_reset),
		.cpu_wait   (cpu_wait)
	);

	ram_eraser i_ram_eraser (
		.sys_clock    (sys_clock),
		.RESET        (RESET),
		.cpu_ena      (cpu_ena),
		.erase_trigger(erase_trigger),
		.erase_busy   (erase_busy),
		.erase_req    (erase_req)
	);

	rom_checker i_rom_checker (
		.sys_clock (sys_clock),
		.RESET     (RESET),
		.core_reset(core_reset),
		.cpu_ena   (cpu_ena),
		.rom_loaded(rom_loaded),
		.rdata     (ram_rdata),
		.check_busy(check_busy),
		.check_done(check_done),
		.check_req (check_req),
		.led       (led)
	);

	ram_arbiter i_ram_arbiter (
		.download_req(download_req),
		.erase_req   (erase_req),
		.check_req   (check_req),
		.cpu_req     (cpu_req),
		.downloading (downloading),
		.erase_busy  (erase_busy),
		.check_busy  (check_busy),
		.ram_req     (ram_req)
	);

	sys_ram i_sys_ram (
		.sys_clock(sys_clock),
		.req      (ram_req),
		.rdata    (ram_rdata)
	);

	assign cpu_rdata = ram_rdata;   // same read bus as the checker

	audio_dac i_dac_l (
		.sys_clock(sys_clock),
		.RESET    (RESET),
		.sample   (channel_l),
		.dac_out  (audio_l)
	);

	audio_dac i_dac_r (
		.sys_clock(sys_clock),
		.RESET    (RESET),
		.sample   (channel_r),
		.dac_out  (audio_r)
	);

endmodule

// File: tests/tb_checks.svh
/* typed compare tasks, bounded wait and count tasks, error counter */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int err_cnt = 0;   // failed checks so far

task automatic check_byte(input string name, input lm80c_pkg::byte_t got,
	input lm80c_pkg::byte_t exp);
	if (got !== exp) begin
		$display("Fail %s: got 0x%02h, expected 0x%02h", name, got, exp);
		err_cnt++;
	end
endtask

task automatic check_level(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
		err_cnt++;
	end
endtask

task automatic check_count(input string name, input int got, input int exp);
	if (got !== exp) begin
		$display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
		err_cnt++;
	end
endtask

// cpu released once the boot check is finished
task automatic wait_boot_done(input int limit);
	int n;
	n = 0;
	do begin
		@(negedge sys_clock);
		n++;
	end while (cpu_wait !== 1'b0 && n < limit);
	if (cpu_wait !== 1'b0) begin
		$display("Timed out waiting for the boot check to release cpu_wait.");
		err_cnt++;
	end
endtask

// also counts cpu enables seen while core_reset is high
task automatic wait_core_reset(input logic level, input int limit, inout int ena_seen);
	int n;
	n = 0;
	do begin
		@(negedge sys_clock);
		n++;
		if (core_reset === 1'b1 && cpu_ena === 1'b1) ena_seen++;
	end while (core_reset !== level && n < limit);
	if (core_reset !== level) begin
		$display("Timed out waiting for core_reset to go %s.", level ? "high" : "low");
		err_cnt++;
	end
endtask

task automatic count_enables(input int cycles, output int n);
	n = 0;
	repeat (cycles) begin
		@(negedge sys_clock);
		if (cpu_ena === 1'b1) n++;
	end
endtask

task automatic count_dac(input int cycles, output int ones_l, output int ones_r);
	ones_l = 0;
	ones_r = 0;
	repeat (cycles) begin
		@(negedge sys_clock);
		if (audio_l === 1'b1) ones_l++;
		if (audio_r === 1'b1) ones_r++;
	end
endtask

`endif

// File: tests/tb_lm80c_memsys.sv
/* testbench for the lm80c memory supervisor, clock, reset, stimulus table
   with boot, download, erase, cpu access and dac entries */
module tb_lm80c_memsys;

	typedef enum logic [2:0] {
		OP_RESET_STATE, OP_DL_WR, OP_CPU_WR, OP_CPU_RD, OP_BOOT, OP_RELOAD, OP_ERASE, OP_DAC
	} op_t;

	typedef struct packed {
		op_t              op;
		lm80c_pkg::addr_t addr;
		lm80c_pkg::byte_t data;
		lm80c_pkg::byte_t exp;   // read byte, led level or right dac sample
	} entry_t;

	logic                sys_clock;
	logic                RESET;
	logic                reset_key;
	logic                downloading;
	logic                rom_loaded;
	logic                download_wr;
	lm80c_pkg::addr_t    download_addr;
	lm80c_pkg::byte_t    download_data;
	logic                erase_trigger;
	lm80c_pkg::mem_req_t cpu_req;
	lm80c_pkg::byte_t    channel_l;
	lm80c_pkg::byte_t    channel_r;
	logic                cpu_ena;
	logic                core_reset;
	logic                cpu_wait;
	lm80c_pkg::byte_t    cpu_rdata;
	logic                led;
	logic                audio_l;
	logic                audio_r;

	entry_t           stim_q[$];
	lm80c_pkg::byte_t boot_sig [4];   // good rom, addr 0..3
	lm80c_pkg::addr_t tab_addr [4];
	lm80c_pkg::byte_t rnd [4];
	int               seed;
	int               fail_tests = 0;

	`include "tb_checks.svh"

	lm80c_memsys i_dut (
		.sys_clock    (sys_clock),
		.RESET        (RESET),
		.reset_key    (reset_key),
		.downloading  (downloading),
		.rom_loaded   (rom_loaded),
		.download_wr  (download_wr),
		.download_addr(download_addr),
		.download_data(download_data),
		.erase_trigger(erase_trigger),
		.cpu_req      (cpu_req),
		.channel_l    (channel_l),
		.channel_r    (channel_r),
		.cpu_ena      (cpu_ena),
		.core_reset   (core_reset),
		.cpu_wait     (cpu_wait),
		.cpu_rdata    (cpu_rdata),
		.led          (led),
		.audio_l      (audio_l),
		.audio_r      (audio_r)
	);

	initial begin
		sys_clock = 1'b0;
		forever #4 sys_clock = ~sys_clock;   // period 8
	end

	function automatic void add_entry(op_t op, lm80c_pkg::addr_t addr,
		lm80c_pkg::byte_t data, lm80c_pkg::byte_t exp);
		entry_t e;
		e.op   = op;
		e.addr = addr;
		e.data = data;
		e.exp  = exp;
		stim_q.push_back(e);
	endfunction

	function automatic string op_name(op_t op);
		case (op)
			OP_RESET_STATE: return "state after reset";
			OP_DL_WR:       return "download write";
			OP_CPU_WR:      return "cpu write";
			OP_CPU_RD:      return "cpu read";
			OP_BOOT:        return "boot check";
			OP_RELOAD:      return "reload start";
			OP_ERASE:       return "ram erase";
			default:        return "audio dac";
		endcase
	endfunction

	// called on a falling edge, returns on a falling edge
	task automatic run_entry(input entry_t e, input int idx);
		int n;
		int ones_l;
		int ones_r;
		int ena_seen;
		int err_before;
		err_before = err_cnt;
		case (e.op)
			OP_RESET_STATE: begin
				check_level("core_reset", core_reset, 1'b1);
				check_level("cpu_wait", cpu_wait, 1'b1);
				check_level("led", led, 1'b1);
				repeat (4) begin
					count_enables(8, n);   // one pulse per 8 clocks
					check_count("cpu_ena pulses", n, 1);
				end
			end
			OP_DL_WR: begin
				downloading   = 1'b1;
				download_addr = e.addr;
				download_data = e.data;
				download_wr   = 1'b1;
				@(negedge sys_clock);
				download_wr = 1'b0;
			end
			OP_CPU_WR: begin
				cpu_req.addr = e.addr;
				cpu_req.data = e.data;
				cpu_req.wr   = 1'b1;
				@(negedge sys_clock);
				cpu_req = '0;
			end
			OP_CPU_RD: begin
				cpu_req.addr = e.addr;
				cpu_req.rd   = 1'b1;
				@(negedge sys_clock);   // data registered one clock later
				check_byte("cpu_rdata", cpu_rdata, e.exp);
				cpu_req = '0;
			end
			OP_BOOT: begin
				downloading = 1'b0;
				rom_loaded  = 1'b1;
				wait_boot_done(200);
				check_level("core_reset", core_reset, 1'b0);
				check_level("led", led, e.exp[0]);
			end
			OP_RELOAD: begin
				rom_loaded  = 1'b0;
				downloading = 1'b1;
				@(negedge sys_clock);
				check_level("core_reset", core_reset, 1'b1);
				check_level("cpu_wait", cpu_wait, 1'b1);
				check_level("led", led, 1'b1);
			end
			OP_ERASE: begin
				ena_seen      = 0;
				erase_trigger = 1'b1;
				wait_core_reset(1'b1, 16, ena_seen);
				erase_trigger = 1'b0;
				check_level("core_reset", core_reset, 1'b1);
				wait_core_reset(1'b0, 600000, ena_seen);   // whole 64 KiB
				check_count("erase enables", ena_seen, 65536);
				wait_boot_done(200);   // check reruns on its own
				check_level("led", led, e.exp[0]);
			end
			default: begin
				channel_l = e.data;
				channel_r = e.exp;
				count_dac(256, ones_l, ones_r);
				check_count("audio_l ones", ones_l, e.data);
				check_count("audio_r ones", ones_r, e.exp);
			end
		endcase
		if (err_cnt == err_before) begin
			$display("test %0d, %s: ok", idx, op_name(e.op));
		end else begin
			$display("test %0d, %s: failed", idx, op_name(e.op));
			fail_tests++;
		end
	endtask

	initial begin
		seed          = 32'h8fbb;
		RESET         = 1'b1;
		reset_key     = 1'b0;
		downloading   = 1'b0;
		rom_loaded    = 1'b0;
		download_wr   = 1'b0;
		download_addr = '0;
		download_data = '0;
		erase_trigger = 1'b0;
		cpu_req       = '0;
		channel_l     = '0;
		channel_r     = '0;
		boot_sig = '{8'hf3, 8'hc3, 8'h5a, 8'h02};
		tab_addr = '{16'h0100, 16'h1234, 16'h8000, 16'hfffe};
		for (int i = 0; i < 4; i++) rnd[i] = $random(seed);
		repeat (8) @(negedge sys_clock);
		RESET = 1'b0;

		add_entry(OP_RESET_STATE, 16'h0, 8'h00, 8'h00);
		for (int i = 0; i < 4; i++) add_entry(OP_DL_WR, i, boot_sig[i], 8'h00);
		for (int i = 0; i < 4; i++) add_entry(OP_DL_WR, tab_addr[i], rnd[i], 8'h00);
		add_entry(OP_CPU_WR, tab_addr[0], ~rnd[0], 8'h00);   // blocked, still loading
		add_entry(OP_BOOT, 16'h0, 8'h00, 8'h00);             // good rom, led on
		for (int i = 0; i < 4; i++) add_entry(OP_CPU_RD, i, 8'h00, boot_sig[i]);
		for (int i = 0; i < 4; i++) add_entry(OP_CPU_RD, tab_addr[i], 8'h00, rnd[i]);
		// second run with a bad byte at addr 2
		add_entry(OP_RELOAD, 16'h0, 8'h00, 8'h00);
		add_entry(OP_DL_WR, 16'h2, 8'ha5, 8'h00);
		add_entry(OP_BOOT, 16'h0, 8'h00, 8'h01);
		add_entry(OP_RELOAD, 16'h0, 8'h00, 8'h00);   // repair before the erase
		add_entry(OP_DL_WR, 16'h2, boot_sig[2], 8'h00);
		add_entry(OP_BOOT, 16'h0, 8'h00, 8'h00);
		add_entry(OP_ERASE, 16'h0, 8'h00, 8'h01);    // zeros fail the rerun
		for (int i = 0; i < 4; i++) add_entry(OP_CPU_RD, i, 8'h00, 8'h00);
		for (int i = 0; i < 4; i++) add_entry(OP_CPU_RD, tab_addr[i], 8'h00, 8'h00);
		add_entry(OP_DAC, 16'h0, 8'h40, 8'hc5);
		add_entry(OP_DAC, 16'h0, $random(seed), $random(seed));

		foreach (stim_q[i]) run_entry(stim_q[i], i);

		$display("tests: %0d, failed tests: %0d, failed checks: %0d",
			stim_q.size(), fail_tests, err_cnt);
		if (err_cnt == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: verilog.f
+incdir+tests
design/lm80c_pkg.sv
design/boot_control.sv
design/ram_eraser.sv
design/rom_checker.sv
design/ram_arbiter.sv
design/sys_ram.sv
design/audio_dac.sv
design/lm80c_memsys.sv
tests/tb_lm80c_memsys.sv
